//--- source/lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Register and memory data width.
`define LSU_DATA_WIDTH 32

`define LSU_ADDR_WIDTH 32

`define LSU_SIZE_WIDTH 3

// Burst length field, kept for bus compatibility.
`define LSU_LEN_WIDTH 8

// Word count of the data memory.
`define LSU_MEM_WORDS 256

// Valid cycles up to and including the response cycle.
`define LSU_MEM_LATENCY 2

`endif

//--- source/lsu_pkg.sv
`include "lsu_defines.svh"

package lsu_pkg;

  typedef enum logic [1:0] {
    op_none  = 2'd0,
    op_load  = 2'd1,
    op_store = 2'd2
  } lsu_op_e;

  // One memory instruction as issued by the pipeline.
  typedef struct packed {
    lsu_op_e                    op;
    logic [2:0]                 funct3;
    logic [`LSU_DATA_WIDTH-1:0] src1;    // Base register.
    logic [`LSU_DATA_WIDTH-1:0] src2;    // Store data.
    logic [`LSU_DATA_WIDTH-1:0] imm;
  } lsu_req_t;

  typedef struct packed {
    logic                       valid;
    logic [`LSU_ADDR_WIDTH-1:0] addr;
    logic [`LSU_SIZE_WIDTH-1:0] size;
    logic [`LSU_LEN_WIDTH-1:0]  len;
  } mem_rd_req_t;

  typedef struct packed {
    logic                       valid;
    logic [`LSU_ADDR_WIDTH-1:0] addr;
    logic [`LSU_DATA_WIDTH-1:0] data;
    logic [`LSU_SIZE_WIDTH-1:0] size;
    logic [`LSU_LEN_WIDTH-1:0]  len;
  } mem_wr_req_t;

  typedef struct packed {
    logic                       ready;
    logic                       last;
    logic [`LSU_DATA_WIDTH-1:0] data;    // Already shifted down to bit 0.
  } mem_rd_rsp_t;

endpackage

//--- source/lsu.sv
`timescale 1ns/100ps
`include "lsu_defines.svh"

module lsu (
  input  logic                       clk,
  input  logic                       reset,
  input  lsu_pkg::lsu_req_t          req_i,
  input  logic                       ifu_stall_i,
  output lsu_pkg::mem_rd_req_t       rd_req_o,
  input  lsu_pkg::mem_rd_rsp_t       rd_rsp_i,
  output lsu_pkg::mem_wr_req_t       wr_req_o,
  input  logic                       wr_last_i,
  output logic                       mem_stall_o,
  output logic                       rd_wen_o,
  output logic [`LSU_DATA_WIDTH-1:0] result_o
);

  logic [`LSU_ADDR_WIDTH-1:0] addr;
  logic [`LSU_SIZE_WIDTH-1:0] size;
  logic [`LSU_DATA_WIDTH-1:0] rdata;
  logic                       is_load;
  logic                       is_store;
  logic                       load_ok;
  logic                       store_ok;
  logic                       start_rd;
  logic                       start_wr;
  logic                       rd_done;
  logic                       wr_done;
  logic                       ren;
  logic                       wen;
  logic                       aligned;

  assign addr     = `LSU_ADDR_WIDTH'(req_i.src1 + req_i.imm);
  assign is_load  = req_i.op == lsu_pkg::op_load;
  assign is_store = req_i.op == lsu_pkg::op_store;

  // Unused funct3 codes never start an access.
  assign load_ok  = is_load && (req_i.funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
  assign store_ok = is_store && (req_i.funct3 inside {3'b000, 3'b001, 3'b010});

  assign start_rd = load_ok && !ifu_stall_i;
  assign start_wr = store_ok && !ifu_stall_i;

  always_comb begin
    case (req_i.funct3)
      3'b000, 3'b100: size = 3'd0;
      3'b001, 3'b101: size = 3'd1;
      3'b010:         size = 3'd2;
      default:        size = 3'd0;
    endcase
  end

  always_comb begin
    case (size)
      3'd1:    aligned = ~addr[0];
      3'd2:    aligned = addr[1:0] == 2'b00;
      default: aligned = 1'b1;
    endcase
  end

  assign rd_done  = rd_rsp_i.ready & rd_rsp_i.last;
  assign wr_done  = wr_last_i;
  assign rd_wen_o = rd_done | wr_done;

  // Completion wins over a new start, so valid drops for at least one cycle.
  always_ff @(posedge clk) begin
    if (reset) begin
      ren <= 1'b0;
      wen <= 1'b0;
    end else if (rd_wen_o) begin
      ren <= 1'b0;
      wen <= 1'b0;
    end else begin
      if (start_rd) begin
        ren <= 1'b1;
      end
      if (start_wr) begin
        wen <= 1'b1;
      end
    end
  end

  assign mem_stall_o = (ren | wen) & ~rd_wen_o;

  assign rd_req_o.valid = ren;
  assign rd_req_o.addr  = load_ok ? addr : '0;   // Idle channel sees a zero address.
  assign rd_req_o.size  = load_ok ? size : '0;
  assign rd_req_o.len   = '0;

  assign wr_req_o.valid = wen;
  assign wr_req_o.addr  = store_ok ? addr : '0;
  assign wr_req_o.data  = req_i.src2;
  assign wr_req_o.size  = store_ok ? size : '0;
  assign wr_req_o.len   = '0;

  assign rdata = rd_rsp_i.data;

  always_comb begin
    result_o = '0;
    if (is_load) begin
      case (req_i.funct3)
        3'b000:  result_o = {{(`LSU_DATA_WIDTH-8){rdata[7]}}, rdata[7:0]};
        3'b001:  result_o = {{(`LSU_DATA_WIDTH-16){rdata[15]}}, rdata[15:0]};
        3'b010:  result_o = rdata;
        3'b100:  result_o = {{(`LSU_DATA_WIDTH-8){1'b0}}, rdata[7:0]};
        3'b101:  result_o = {{(`LSU_DATA_WIDTH-16){1'b0}}, rdata[15:0]};
        default: result_o = '0;
      endcase
    end
  end

  // Only one channel may be in flight at a time.
  a_flags_exclusive: assert property (
    @(posedge clk) disable iff (reset) !(ren && wen)
  );

  a_start_aligned: assert property (
    @(posedge clk) disable iff (reset) (start_rd || start_wr) |-> aligned
  );

endmodule

//--- source/data_sram.sv
`timescale 1ns/100ps
`include "lsu_defines.svh"

module data_sram (
  input  logic                 clk,
  input  logic                 reset,
  input  lsu_pkg::mem_rd_req_t rd_req_i,
  input  lsu_pkg::mem_wr_req_t wr_req_i,
  output lsu_pkg::mem_rd_rsp_t rd_rsp_o,
  output logic                 wr_last_o
);

  localparam int IDX_W = $clog2(`LSU_MEM_WORDS);
  localparam int CNT_W = $clog2(`LSU_MEM_LATENCY + 1);
  localparam int LANES = `LSU_DATA_WIDTH / 8;

  logic [`LSU_DATA_WIDTH-1:0] mem [`LSU_MEM_WORDS];

  logic [CNT_W-1:0]           cnt;
  logic                       done;
  logic                       any_valid;
  logic                       pulse;
  logic                       rd_pulse;
  logic                       wr_pulse;
  logic [IDX_W-1:0]           rd_idx;
  logic [IDX_W-1:0]           wr_idx;
  logic [1:0]                 wr_off;
  logic [LANES-1:0]           lane_base;
  logic [LANES-1:0]           be;
  logic [`LSU_DATA_WIDTH-1:0] wdata_sh;
  logic [`LSU_DATA_WIDTH-1:0] rword;

  assign any_valid = rd_req_i.valid | wr_req_i.valid;

  // Fires on the last latency cycle, once per valid level.
  assign pulse    = any_valid & ~done & (cnt == CNT_W'(`LSU_MEM_LATENCY - 1));
  assign rd_pulse = pulse & rd_req_i.valid;
  assign wr_pulse = pulse & wr_req_i.valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt  <= '0;
      done <= 1'b0;
    end else if (!any_valid) begin
      cnt  <= '0;
      done <= 1'b0;
    end else if (pulse) begin
      cnt  <= '0;
      done <= 1'b1;   // Hold off until valid drops.
    end else if (!done) begin
      cnt <= cnt + 1'b1;
    end
  end

  assign rd_idx = rd_req_i.addr[IDX_W+1:2];
  assign wr_idx = wr_req_i.addr[IDX_W+1:2];
  assign wr_off = wr_req_i.addr[1:0];

  always_comb begin
    case (wr_req_i.size)
      3'd0:    lane_base = LANES'(4'b0001);
      3'd1:    lane_base = LANES'(4'b0011);
      default: lane_base = LANES'(4'b1111);
    endcase
  end

  assign be       = lane_base << wr_off;
  assign wdata_sh = wr_req_i.data << {wr_off, 3'b000};

  always_ff @(posedge clk) begin
    if (wr_pulse) begin
      for (int i = 0; i < LANES; i++) begin
        if (be[i]) begin
          mem[wr_idx][8*i +: 8] <= wdata_sh[8*i +: 8];
        end
      end
    end
  end

  assign rword = mem[rd_idx];

  assign rd_rsp_o.ready = rd_pulse;
  assign rd_rsp_o.last  = rd_pulse;   // Single beat, so last rides with ready.
  assign rd_rsp_o.data  = rword >> {rd_req_i.addr[1:0], 3'b000};
  assign wr_last_o      = wr_pulse;

  a_len_zero: assert property (
    @(posedge clk) disable iff (reset)
    (rd_req_i.valid |-> rd_req_i.len == '0) and (wr_req_i.valid |-> wr_req_i.len == '0)
  );

  a_size_max: assert property (
    @(posedge clk) disable iff (reset)
    (rd_req_i.valid |-> rd_req_i.size <= 3'd2) and (wr_req_i.valid |-> wr_req_i.size <= 3'd2)
  );

  // The port is shared, so both channels must never be active together.
  a_one_channel: assert property (
    @(posedge clk) disable iff (reset) !(rd_req_i.valid && wr_req_i.valid)
  );

endmodule

//--- source/lsu_subsystem.sv
`timescale 1ns/100ps
`include "lsu_defines.svh"

module lsu_subsystem (
  input  logic                       clk,
  input  logic                       reset,
  input  lsu_pkg::lsu_req_t          req_i,
  input  logic                       ifu_stall_i,
  output logic                       mem_stall_o,
  output logic                       rd_wen_o,
  output logic [`LSU_DATA_WIDTH-1:0] result_o
);

  lsu_pkg::mem_rd_req_t rd_req;
  lsu_pkg::mem_wr_req_t wr_req;
  lsu_pkg::mem_rd_rsp_t rd_rsp;
  logic                 wr_last;

  lsu lsu_i (
    .clk         (clk),
    .reset       (reset),
    .req_i       (req_i),
    .ifu_stall_i (ifu_stall_i),
    .rd_req_o    (rd_req),
    .rd_rsp_i    (rd_rsp),
    .wr_req_o    (wr_req),
    .wr_last_i   (wr_last),
    .mem_stall_o (mem_stall_o),
    .rd_wen_o    (rd_wen_o),
    .result_o    (result_o)
  );

  data_sram data_sram_i (
    .clk       (clk),
    .reset     (reset),
    .rd_req_i  (rd_req),
    .wr_req_i  (wr_req),
    .rd_rsp_o  (rd_rsp),
    .wr_last_o (wr_last)
  );

endmodule

//--- tb/lsu_tb.sv
`timescale 1ns/100ps
`include "lsu_defines.svh"

module lsu_tb;

  typedef struct packed {
    lsu_pkg::lsu_req_t          req;
    logic [3:0]                 stall;   // Cycles of ifu_stall_i before release.
    logic [`LSU_DATA_WIDTH-1:0] exp;
  } row_t;

  logic                       clk;
  logic                       reset;
  lsu_pkg::lsu_req_t          req_i;
  logic                       ifu_stall_i;
  logic                       mem_stall_o;
  logic                       rd_wen_o;
  logic [`LSU_DATA_WIDTH-1:0] result_o;

  row_t       table_q[$];
  logic [7:0] ref_mem [1024];   // Byte image of the memory, address bits 9 to 0.
  integer     seed;

  lsu_subsystem lsu_subsystem_inst (
    .clk         (clk),
    .reset       (reset),
    .req_i       (req_i),
    .ifu_stall_i (ifu_stall_i),
    .mem_stall_o (mem_stall_o),
    .rd_wen_o    (rd_wen_o),
    .result_o    (result_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_data(input string name, input logic [`LSU_DATA_WIDTH-1:0] got,
                            input logic [`LSU_DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("Regression failed");
      $fatal(1, "Stopped at the first mismatch.");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("Regression failed");
      $fatal(1, "Stopped at the first mismatch.");
    end
  endtask

  function automatic bit starts_access(input lsu_pkg::lsu_req_t r);
    if (r.op == lsu_pkg::op_load) begin
      return r.funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
    end
    if (r.op == lsu_pkg::op_store) begin
      return r.funct3 inside {3'b000, 3'b001, 3'b010};
    end
    return 1'b0;
  endfunction

  function automatic logic [31:0] model_load(input logic [31:0] addr, input logic [2:0] funct3);
    logic [9:0] a;
    logic [7:0] b0;
    logic [7:0] b1;
    a  = addr[9:0];
    b0 = ref_mem[a];
    b1 = ref_mem[a + 10'd1];
    case (funct3)
      3'b000:  return {{24{b0[7]}}, b0};
      3'b001:  return {{16{b1[7]}}, b1, b0};
      3'b010:  return {ref_mem[a + 10'd3], ref_mem[a + 10'd2], b1, b0};
      3'b100:  return {24'd0, b0};
      3'b101:  return {16'd0, b1, b0};
      default: return 32'd0;
    endcase
  endfunction

  task automatic model_store(input logic [31:0] addr, input logic [31:0] data,
                             input logic [2:0] funct3);
    int nbytes;
    nbytes = 1 << funct3[1:0];
    for (int i = 0; i < nbytes; i++) begin
      ref_mem[addr[9:0] + 10'(i)] = data[8*i +: 8];
    end
  endtask

  task automatic add_row(input lsu_pkg::lsu_op_e op, input logic [2:0] f3,
                         input logic [31:0] src1, input logic [31:0] src2,
                         input logic [31:0] imm, input logic [3:0] stall,
                         input logic [31:0] exp);
    row_t row;
    row.req.op     = op;
    row.req.funct3 = f3;
    row.req.src1   = src1;
    row.req.src2   = src2;
    row.req.imm    = imm;
    row.stall      = stall;
    row.exp        = exp;
    table_q.push_back(row);
  endtask

  task automatic build_table();
    // op, funct3, src1 (base), src2 (store data), imm, stall cycles, expected result
    add_row(lsu_pkg::op_store, 3'b010, 32'h0000_0000, 32'h1234_5678, 32'h10, 4'd0, 32'h0);
    add_row(lsu_pkg::op_store, 3'b010, 32'h0000_0010, 32'hdead_beef, 32'h04, 4'd0, 32'h0);
    add_row(lsu_pkg::op_load,  3'b010, 32'h0000_0000, 32'h0, 32'h10, 4'd0, 32'h1234_5678);
    add_row(lsu_pkg::op_load,  3'b010, 32'h0000_0020, 32'h0, 32'hffff_fff4, 4'd0, 32'hdead_beef);
    add_row(lsu_pkg::op_store, 3'b010, 32'h0000_0020, 32'h0000_0000, 32'h0, 4'd0, 32'h0);
    add_row(lsu_pkg::op_store, 3'b000, 32'h0000_0020, 32'h0000_00a5, 32'h1, 4'd0, 32'h0);
    add_row(lsu_pkg::op_store, 3'b001, 32'h0000_0020, 32'h0000_8001, 32'h2, 4'd0, 32'h0);
    add_row(lsu_pkg::op_load,  3'b000, 32'h0000_0020, 32'h0, 32'h1, 4'd0, 32'hffff_ffa5);
    add_row(lsu_pkg::op_load,  3'b100, 32'h0000_0020, 32'h0, 32'h1, 4'd0, 32'h0000_00a5);
    add_row(lsu_pkg::op_load,  3'b001, 32'h0000_0020, 32'h0, 32'h2, 4'd0, 32'hffff_8001);
    add_row(lsu_pkg::op_load,  3'b101, 32'h0000_0020, 32'h0, 32'h2, 4'd0, 32'h0000_8001);
    add_row(lsu_pkg::op_load,  3'b010, 32'h0000_0020, 32'h0, 32'h0, 4'd0, 32'h8001_a500);
    add_row(lsu_pkg::op_load,  3'b001, 32'h0000_0020, 32'h0, 32'h0, 4'd0, 32'hffff_a500);
    add_row(lsu_pkg::op_load,  3'b100, 32'h0000_0020, 32'h0, 32'h0, 4'd0, 32'h0000_0000);
    add_row(lsu_pkg::op_load,  3'b000, 32'h0000_0020, 32'h0, 32'h3, 4'd0, 32'hffff_ff80);
    add_row(lsu_pkg::op_load,  3'b010, 32'h0000_0010, 32'h0, 32'h0, 4'd5, 32'h1234_5678);
    add_row(lsu_pkg::op_store, 3'b000, 32'h0000_0010, 32'h0000_007f, 32'h3, 4'd3, 32'h0);
    add_row(lsu_pkg::op_load,  3'b010, 32'h0000_0010, 32'h0, 32'h0, 4'd2, 32'h7f34_5678);
    add_row(lsu_pkg::op_none,  3'b010, 32'h0000_0010, 32'h0, 32'h0, 4'd0, 32'h0);
    add_row(lsu_pkg::op_load,  3'b011, 32'h0000_0010, 32'h0, 32'h0, 4'd0, 32'h0);
    add_row(lsu_pkg::op_load,  3'b110, 32'h0000_0020, 32'h0, 32'h0, 4'd0, 32'h0);
  endtask

  task automatic apply_row(input row_t row);
    int  n_stall;
    int  cycles;
    bit  seen;
    n_stall = int'(row.stall);
    @(posedge clk);
    req_i       <= row.req;
    ifu_stall_i <= (n_stall != 0);
    for (int k = 0; k < n_stall; k++) begin
      @(negedge clk);
      check_bit("mem_stall_o", mem_stall_o, 1'b0);
      check_bit("rd_wen_o", rd_wen_o, 1'b0);
      @(posedge clk);
      if (k == n_stall - 1) begin
        ifu_stall_i <= 1'b0;   // Released here, so the access starts at the next edge.
      end
    end
    if (!starts_access(row.req)) begin
      repeat (4) begin
        @(negedge clk);
        check_bit("mem_stall_o", mem_stall_o, 1'b0);
        check_bit("rd_wen_o", rd_wen_o, 1'b0);
        check_data("result_o", result_o, row.exp);
      end
    end else begin
      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles < 20) begin
        @(negedge clk);
        cycles++;
        // Cycle 2 follows the request edge and cycle 3 carries the response.
        check_bit("mem_stall_o", mem_stall_o, cycles == 2);
        check_bit("rd_wen_o", rd_wen_o, cycles == 3);
        if (rd_wen_o) begin
          seen = 1'b1;
          check_data("result_o", result_o, row.exp);
        end
      end
      if (!seen) begin
        $display("Timed out after 20 cycles waiting for rd_wen_o.");
        $display("Regression failed");
        $fatal(1, "No completion from the memory.");
      end
    end
  endtask

  task automatic run_row(input row_t row);
    apply_row(row);
    if (row.req.op == lsu_pkg::op_store && starts_access(row.req)) begin
      model_store(row.req.src1 + row.req.imm, row.req.src2, row.req.funct3);
    end
  endtask

  task automatic run_random(input int count);
    row_t        row;
    logic [31:0] r;
    logic [31:0] addr;
    for (int n = 0; n < count; n++) begin
      r = $random(seed);
      if (r[8]) begin
        row.req.op     = lsu_pkg::op_store;
        row.req.funct3 = (r[10:9] == 2'd3) ? 3'b010 : {1'b0, r[10:9]};
      end else begin
        row.req.op = lsu_pkg::op_load;
        case (r[12:10])
          3'd0:    row.req.funct3 = 3'b000;
          3'd1:    row.req.funct3 = 3'b001;
          3'd3:    row.req.funct3 = 3'b100;
          3'd4:    row.req.funct3 = 3'b101;
          default: row.req.funct3 = 3'b010;
        endcase
      end
      addr = (32'h100 | {26'd0, r[5:0]}) & ~((32'd1 << row.req.funct3[1:0]) - 32'd1);
      row.req.src1 = $random(seed);
      row.req.imm  = addr - row.req.src1;
      row.req.src2 = $random(seed);
      row.stall    = {2'b00, r[14:13]};
      row.exp      = (row.req.op == lsu_pkg::op_load) ? model_load(addr, row.req.funct3) : 32'h0;
      run_row(row);
    end
  endtask

  initial begin
    reset       = 1'b1;
    req_i       = '0;
    req_i.op    = lsu_pkg::op_load;   // A load waits through reset, so only reset holds valid low.
    ifu_stall_i = 1'b0;
    seed        = 32'hc028;
    build_table();
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    req_i <= '0;
    @(negedge clk);
    check_bit("mem_stall_o", mem_stall_o, 1'b0);
    check_bit("rd_wen_o", rd_wen_o, 1'b0);
    foreach (table_q[i]) begin
      run_row(table_q[i]);
    end
    // Fill the random window so every later load reads known data.
    for (int w = 0; w < 16; w++) begin
      add_row(lsu_pkg::op_store, 3'b010, 32'h100, 32'h100 + 32'(4 * w), 32'(4 * w), 4'd0, 32'h0);
      table_q[$].req.src2 = (32'h100 + 32'(4 * w)) * 32'h9e37_79b1 + 32'h1234;
      run_row(table_q[$]);
    end
    run_random(40);
    @(posedge clk);
    req_i <= '0;
    @(negedge clk);
    check_bit("mem_stall_o", mem_stall_o, 1'b0);
    $display("Regression passed");
    $finish;
  end

endmodule

//--- project.f
+incdir+source
source/lsu_pkg.sv
source/lsu.sv
source/data_sram.sv
source/lsu_subsystem.sv
tb/lsu_tb.sv

//--- Makefile
# Verilator build and run for the LSU subsystem testbench.

VERILATOR ?= verilator
TOP       ?= lsu_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

SOURCES := $(wildcard source/*.sv source/*.svh tb/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJ_DIR)
